/* source/chipBusPkg.sv */
package chipBusPkg;

    ////////////////////////////////////////
    // Cycle timing, CLK80 periods
    ////////////////////////////////////////

    // asN and regEnN low time
    localparam int regHoldCycles = 8;

    // RAS fall to CAS fall
    localparam int rasToCas = 2;

    // CAS low ahead of the acknowledge
    localparam int casHold = 3;

    // Sequencer counter sizes
    localparam int regCntWidth = $clog2(regHoldCycles);
    localparam int ramCntWidth = $clog2(rasToCas + casHold);

    // Terminal counts
    localparam logic [regCntWidth-1:0] regCntLast = regCntWidth'(regHoldCycles - 1);
    localparam logic [ramCntWidth-1:0] rasCntLast = ramCntWidth'(rasToCas - 1);
    localparam logic [ramCntWidth-1:0] casCntLast = ramCntWidth'(casHold - 1);

    ////////////////////////////////////////
    // Chip memory address
    ////////////////////////////////////////

    localparam int cmaWidth = 11;
    // Row phase starts here on the CPU address
    localparam int rowLsb = 11;

    ////////////////////////////////////////
    // 68030 SIZ encodings
    ////////////////////////////////////////

    localparam logic [1:0] sizeLong = 2'b00;
    localparam logic [1:0] sizeByte = 2'b01;
    localparam logic [1:0] sizeWord = 2'b10;
    localparam logic [1:0] sizeThree = 2'b11;

endpackage

/* source/registerCycle.sv */
`timescale 1ns/1ps

module registerCycle (
    input  logic CLK80,
    input  logic RESETn,
    input  logic tsN,
    input  logic regSpaceN,
    input  logic c3,
    output logic asN,
    output logic regEnN,
    output logic regTack,
    output logic regCycle,
    output logic dsEn
);

    typedef enum logic [1:0] {
        regIdle,
        regWaitC3,
        regStrobe
    } regStateT;

    regStateT regState;
    logic [2:0] c3Sync;
    logic c3Rise;
    logic [chipBusPkg::regCntWidth-1:0] holdCnt;

    ////////////////////////////////////////
    // c3 into the CLK80 domain
    ////////////////////////////////////////

    // Two flops for metastability, third for the edge
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            c3Sync <= 3'b000;
        end else begin
            c3Sync <= {c3Sync[1:0], c3};
        end
    end

    assign c3Rise = c3Sync[1] & ~c3Sync[2];

    ////////////////////////////////////////
    // Register access FSM
    ////////////////////////////////////////

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            regState <= regIdle;
            holdCnt <= '0;
        end else begin
            case (regState)
                // Latch the request at the tsN sample
                regIdle: begin
                    if (!tsN && !regSpaceN) begin
                        regState <= regWaitC3;
                    end
                end
                // Line up with the chip bus phase
                regWaitC3: begin
                    if (c3Rise) begin
                        regState <= regStrobe;
                        holdCnt <= '0;
                    end
                end
                // Strobes out, count the hold time
                regStrobe: begin
                    if (regTack) begin
                        regState <= regIdle;
                    end else begin
                        holdCnt <= holdCnt + 1'b1;
                    end
                end
                default: begin
                    regState <= regIdle;
                end
            endcase
        end
    end

    // Acknowledge in the last strobe cycle
    assign regTack = (regState == regStrobe) && (holdCnt == chipBusPkg::regCntLast);

    // Strobes decoded from state
    assign asN = (regState != regStrobe);
    assign regEnN = (regState != regStrobe);
    assign dsEn = (regState == regStrobe);

    // Buffers open from request to release
    assign regCycle = (regState != regIdle);

endmodule

/* source/chipRamCycle.sv */
`timescale 1ns/1ps

module chipRamCycle (
    input  logic CLK80,
    input  logic RESETn,
    input  logic tsN,
    input  logic ramSpaceN,
    input  logic rnW,
    input  logic dbrN,
    input  logic [20:2] a,
    output logic rasN,
    output logic casN,
    output logic weN,
    output logic [chipBusPkg::cmaWidth-1:0] cma,
    output logic cpuCycle,
    output logic dmaCycle,
    output logic cpuTack,
    output logic dbEnN,
    output logic dbDir
);

    typedef enum logic [2:0] {
        stIdle,
        stRow,
        stColumn,
        stHold,
        stRelease
    } ramStateT;

    ramStateT state;
    logic [1:0] dbrSync;
    logic dmaOwns;
    logic ramReq;
    logic pending;
    logic casActive;
    logic [chipBusPkg::ramCntWidth-1:0] seqCnt;
    logic [chipBusPkg::cmaWidth-1:0] rowAddr;
    logic [chipBusPkg::cmaWidth-1:0] colAddr;

    ////////////////////////////////////////
    // DBR synchronizer
    ////////////////////////////////////////

    // Idles high, Agnus not requesting
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            dbrSync <= 2'b11;
        end else begin
            dbrSync <= {dbrSync[0], dbrN};
        end
    end

    assign dmaOwns = ~dbrSync[1];
    assign dmaCycle = dmaOwns;

    // CPU asks for chip RAM
    assign ramReq = ~tsN & ~ramSpaceN;

    ////////////////////////////////////////
    // RAS/CAS sequencer
    ////////////////////////////////////////

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state <= stIdle;
            pending <= 1'b0;
            seqCnt <= '0;
        end else begin
            case (state)
                stIdle: begin
                    // Start at once unless DMA has the bus
                    if ((ramReq || pending) && !dmaOwns) begin
                        state <= stRow;
                        pending <= 1'b0;
                        seqCnt <= '0;
                    end else if (ramReq) begin
                        // Park the request behind DMA
                        pending <= 1'b1;
                    end
                end
                // Row address, RAS low
                stRow: begin
                    if (seqCnt == chipBusPkg::rasCntLast) begin
                        state <= stColumn;
                    end else begin
                        seqCnt <= seqCnt + 1'b1;
                    end
                end
                // CAS falls here
                stColumn: begin
                    state <= stHold;
                    seqCnt <= '0;
                end
                stHold: begin
                    if (cpuTack) begin
                        state <= stRelease;
                    end else begin
                        seqCnt <= seqCnt + 1'b1;
                    end
                end
                // RAS and CAS back high, precharge
                stRelease: begin
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Acknowledge after the CAS hold
    assign cpuTack = (state == stHold) && (seqCnt == chipBusPkg::casCntLast);

    // Row bits zero extended, column from the low bits
    always_comb begin
        rowAddr = '0;
        rowAddr[20-chipBusPkg::rowLsb:0] = a[20:chipBusPkg::rowLsb];
    end
    assign colAddr = a[chipBusPkg::cmaWidth+1:2];

    assign casActive = (state == stColumn) || (state == stHold);

    always_comb begin
        case (state)
            stRow: cma = rowAddr;
            stColumn, stHold: cma = colAddr;
            default: cma = '0;
        endcase
    end

    ////////////////////////////////////////
    // Strobes and buffers
    ////////////////////////////////////////

    assign rasN = !((state == stRow) || casActive);
    assign casN = !casActive;
    // Write enable only with CAS
    assign weN = casActive ? ~rnW : 1'b1;

    assign dbEnN = !casActive;
    assign dbDir = rnW;

    // CPU owns the RAM path
    assign cpuCycle = (state != stIdle);

endmodule

/* source/dataLaneControl.sv */
`timescale 1ns/1ps

module dataLaneControl (
    input  logic regCycle,
    input  logic cpuCycle,
    input  logic dmaCycle,
    input  logic dsEn,
    input  logic rnW,
    input  logic aweN,
    input  logic [1:0] siz,
    input  logic [1:0] a,
    output logic cuubeN,
    output logic cumbeN,
    output logic clmbeN,
    output logic cllbeN,
    output logic udsN,
    output logic ldsN,
    output logic vbEnN,
    output logic drdEnN,
    output logic drdDir
);

    logic [2:0] laneCount;
    // Index is the byte offset, 0 is the upper lane
    logic [3:0] laneEn;

    ////////////////////////////////////////
    // Size and offset to byte lanes
    ////////////////////////////////////////

    always_comb begin
        laneCount = 3'd4;
        case (siz)
            chipBusPkg::sizeByte: laneCount = 3'd1;
            chipBusPkg::sizeWord: laneCount = 3'd2;
            chipBusPkg::sizeThree: laneCount = 3'd3;
            chipBusPkg::sizeLong: laneCount = 3'd4;
        endcase
    end

    // From the offset upward, capped at the long word
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            laneEn[k] = (3'(k) >= {1'b0, a}) && (3'(k) < ({1'b0, a} + laneCount));
        end
    end

    assign cuubeN = ~(cpuCycle & laneEn[0]);
    assign cumbeN = ~(cpuCycle & laneEn[1]);
    assign clmbeN = ~(cpuCycle & laneEn[2]);
    assign cllbeN = ~(cpuCycle & laneEn[3]);

    // Even bytes on UDS, odd on LDS
    assign udsN = ~(dsEn & (laneEn[0] | laneEn[2]));
    assign ldsN = ~(dsEn & (laneEn[1] | laneEn[3]));

    ////////////////////////////////////////
    // Chip bus buffers
    ////////////////////////////////////////

    assign vbEnN = ~(cpuCycle | regCycle);
    assign drdEnN = ~dmaCycle;
    // Agnus sets direction during DMA, else the CPU
    assign drdDir = dmaCycle ? aweN : rnW;

endmodule

/* source/cycleTerm.sv */
`timescale 1ns/1ps

module cycleTerm (
    input  logic CLK80,
    input  logic RESETn,
    input  logic regTack,
    input  logic cpuTack,
    output logic tackN
);

    logic anyTack;

    ////////////////////////////////////////
    // Transfer acknowledge
    ////////////////////////////////////////

    // Either state machine can end the cycle
    assign anyTack = regTack | cpuTack;

    // One cycle low after an acknowledge
    // blocked if tackN went low last cycle
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            tackN <= 1'b1;
        end else begin
            tackN <= ~(anyTack & tackN);
        end
    end

endmodule

/* source/chipBusTop.sv */
`timescale 1ns/1ps

module chipBusTop (
    input  logic CLK80,
    input  logic RESETn,
    input  logic tsN,
    input  logic rnW,
    input  logic regSpaceN,
    input  logic ramSpaceN,
    input  logic dbrN,
    input  logic c3,
    input  logic aweN,
    input  logic [1:0] siz,
    input  logic [20:0] a,
    output logic asN,
    output logic regEnN,
    output logic rasN,
    output logic casN,
    output logic weN,
    output logic [chipBusPkg::cmaWidth-1:0] cma,
    output logic dbEnN,
    output logic dbDir,
    output logic vbEnN,
    output logic drdEnN,
    output logic drdDir,
    output logic cuubeN,
    output logic cumbeN,
    output logic clmbeN,
    output logic cllbeN,
    output logic udsN,
    output logic ldsN,
    output logic tackN
);

    // Acknowledge pulses
    logic regTack;
    logic cpuTack;

    // Cycle type levels
    logic regCycle;
    logic cpuCycle;
    logic dmaCycle;
    logic dsEn;

    ////////////////////////////////////////
    // Custom chip registers
    ////////////////////////////////////////

    registerCycle registerCycle_i (.*);

    ////////////////////////////////////////
    // Chip RAM, long word address only
    ////////////////////////////////////////

    chipRamCycle chipRamCycle_i (
        .a (a[20:2]),
        .*
    );

    ////////////////////////////////////////
    // Termination
    ////////////////////////////////////////

    cycleTerm cycleTerm_i (.*);

    ////////////////////////////////////////
    // Byte lanes and buffers
    ////////////////////////////////////////

    dataLaneControl dataLaneControl_i (
        .a (a[1:0]),
        .*
    );

endmodule

/* tests/chipBus_sva.sv */
`timescale 1ns/1ps

module chipBusSva (
    input logic CLK80,
    input logic RESETn,
    input logic c3,
    input logic asN,
    input logic regEnN,
    input logic rasN,
    input logic casN,
    input logic tackN,
    input logic dmaCycle,
    input logic drdEnN,
    input logic drdDir,
    input logic aweN
);

    // Failure count
    int assertFails = 0;

    ////////////////////////////////////////
    // Register cycle
    ////////////////////////////////////////

    // regEnN low time
    regEnLen: assert property (@(posedge CLK80) disable iff (!RESETn)
        $fell(regEnN) |-> ##(chipBusPkg::regHoldCycles) $rose(regEnN))
        else begin
            assertFails = assertFails + 1;
            $error("regEnN low time is not regHoldCycles");
        end

    // Strobe length
    regStrobeLen: assert property (@(posedge CLK80) disable iff (!RESETn)
        $fell(asN) |-> ##(chipBusPkg::regHoldCycles) $rose(asN))
        else begin
            assertFails = assertFails + 1;
            $error("asN low time is not regHoldCycles");
        end

    // Start tied to a rising c3, three flops back
    regAfterC3: assert property (@(posedge CLK80) disable iff (!RESETn)
        $fell(asN) |-> $past(c3, 3) && !$past(c3, 4))
        else begin
            assertFails = assertFails + 1;
            $error("asN fell without a rising c3");
        end

    regTerm: assert property (@(posedge CLK80) disable iff (!RESETn)
        $rose(asN) |-> !tackN)
        else begin
            assertFails = assertFails + 1;
            $error("no tackN as asN released");
        end

    ////////////////////////////////////////
    // Chip RAM and DMA
    ////////////////////////////////////////

    rasToCasGap: assert property (@(posedge CLK80) disable iff (!RESETn)
        $fell(rasN) |-> ##(chipBusPkg::rasToCas) $fell(casN))
        else begin
            assertFails = assertFails + 1;
            $error("casN did not fall rasToCas cycles after rasN");
        end

    // One extra cycle through the tackN flop
    casToTack: assert property (@(posedge CLK80) disable iff (!RESETn)
        $fell(casN) |-> ##(chipBusPkg::casHold + 1) !tackN)
        else begin
            assertFails = assertFails + 1;
            $error("tackN not casHold plus one after casN");
        end

    // No new RAS while Agnus owns the bus
    dmaHoldOff: assert property (@(posedge CLK80) disable iff (!RESETn)
        dmaCycle && rasN |=> rasN)
        else begin
            assertFails = assertFails + 1;
            $error("rasN fell during a DMA window");
        end

    dmaBuffers: assert property (@(posedge CLK80) disable iff (!RESETn)
        dmaCycle |-> !drdEnN && drdDir == aweN)
        else begin
            assertFails = assertFails + 1;
            $error("DMA data buffer control wrong");
        end

    ////////////////////////////////////////
    // Termination
    ////////////////////////////////////////

    tackSingle: assert property (@(posedge CLK80) disable iff (!RESETn)
        !tackN |=> tackN)
        else begin
            assertFails = assertFails + 1;
            $error("tackN low in two consecutive cycles");
        end

endmodule

bind chipBusTop chipBusSva chipBusSva_i (
    .CLK80 (CLK80),
    .RESETn (RESETn),
    .c3 (c3),
    .asN (asN),
    .regEnN (regEnN),
    .rasN (rasN),
    .casN (casN),
    .tackN (tackN),
    .dmaCycle (dmaCycle),
    .drdEnN (drdEnN),
    .drdDir (drdDir),
    .aweN (aweN)
);

/* tests/chipBusTb.sv */
`timescale 1ns/1ps

module chipBusTb;

    localparam int testCount = 6;
    // Run limit, 200 cycles per test
    localparam int cycleLimit = 200 * testCount;
    // Longest wait for one DUT event
    localparam int waitLimit = 60;
    // tsN sample to tackN seen, RAS + CAS + hold + tackN flop
    localparam int ramLatency = 1 + chipBusPkg::rasToCas + chipBusPkg::casHold + 1;

    logic CLK80;
    logic RESETn;
    logic tsN;
    logic rnW;
    logic regSpaceN;
    logic ramSpaceN;
    logic dbrN;
    logic c3;
    logic aweN;
    logic [1:0] siz;
    logic [20:0] a;
    logic asN, regEnN, rasN, casN, weN;
    logic [chipBusPkg::cmaWidth-1:0] cma;
    logic dbEnN, dbDir, vbEnN, drdEnN, drdDir;
    logic cuubeN, cumbeN, clmbeN, cllbeN, udsN, ldsN;
    logic tackN;

    int errorCount = 0;
    int checkCount = 0;
    int testErrors;
    int testChecks;
    int testNumber = 0;
    int tsIssued = 0;
    int tackSeen = 0;
    int cycleCount;
    logic [15:0] lfsrState;

    chipBusTop chipBusTop_i (.*);

    ////////////////////////////////////////
    // Clocks and monitors
    ////////////////////////////////////////

    initial begin
        CLK80 = 1'b0;
        forever #20 CLK80 = ~CLK80;
    end

    // Slow chip bus phase, 14 CLK80 periods
    initial begin
        c3 = 1'b0;
        forever begin
            repeat (7) @(posedge CLK80);
            c3 <= ~c3;
        end
    end

    // Every termination the CPU sees
    always @(negedge CLK80) begin
        if (RESETn && !tackN) begin
            tackSeen++;
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge CLK80);
            cycleCount++;
        end
        $display("Run stopped after %0d cycles, the tests did not finish in time", cycleCount);
        $display("TESTBENCH FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic checkThat(input logic ok, input string what);
        checkCount++;
        assert (ok) else begin
            errorCount++;
            $display("** Error at %0d ns: %s", $time, what);
        end
    endtask

    // Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One step per bit
    function automatic int takeBits(input int n);
        int r;
        int i;
        r = 0;
        for (i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            r = (r << 1) | int'(lfsrState[0]);
        end
        return r;
    endfunction

    // Bit k is byte offset k, 0 the upper lane
    function automatic logic [3:0] expectedLanes(input logic [1:0] s, input logic [1:0] off);
        int count;
        int k;
        logic [3:0] lanes;
        case (s)
            chipBusPkg::sizeByte: count = 1;
            chipBusPkg::sizeWord: count = 2;
            chipBusPkg::sizeThree: count = 3;
            default: count = 4;
        endcase
        for (k = 0; k < 4; k++) begin
            lanes[k] = (k >= int'(off)) && (k < int'(off) + count);
        end
        return lanes;
    endfunction

    task automatic startTest();
        testErrors = errorCount;
        testChecks = checkCount;
        testNumber++;
    endtask

    task automatic endTest(input string name);
        $display("Test %0d %s: %0d checks, %0d errors", testNumber, name,
            checkCount - testChecks, errorCount - testErrors);
    endtask

    task automatic checkIdleOutputs();
        checkThat(asN && regEnN && rasN && casN && weN && tackN, "strobe active in reset");
        checkThat(dbEnN && vbEnN && drdEnN, "buffer enable active in reset");
        checkThat(cuubeN && cumbeN && clmbeN && cllbeN && udsN && ldsN, "lane active in reset");
        checkThat(cma == '0, "cma not zero in reset");
    endtask

    ////////////////////////////////////////
    // Bus cycles
    ////////////////////////////////////////

    task automatic resetTest();
        int i;
        for (i = 0; i < 16; i++) begin
            @(posedge CLK80);
            if (i == 15) begin
                RESETn <= 1'b1;
            end
            @(negedge CLK80);
            checkIdleOutputs();
        end
        // First cycle out of reset
        @(negedge CLK80);
        checkIdleOutputs();
    endtask

    task automatic regAccess(input logic [1:0] s, input logic [20:0] addr);
        int n;
        int low;
        logic [3:0] lanes;
        lanes = expectedLanes(s, addr[1:0]);
        n = 0;
        low = 0;
        @(posedge CLK80);
        tsN <= 1'b0;
        regSpaceN <= 1'b0;
        rnW <= 1'b1;
        siz <= s;
        a <= addr;
        tsIssued++;
        @(posedge CLK80);
        tsN <= 1'b1;
        while (asN && n < waitLimit) begin
            @(negedge CLK80);
            n++;
        end
        checkThat(!asN, "asN never went low after a register request");
        while (!asN && low <= chipBusPkg::regHoldCycles) begin
            checkThat(!regEnN && !vbEnN && tackN,
                "regEnN or vbEnN high, or tackN low, inside the strobe");
            checkThat({udsN, ldsN} == ~{lanes[0] | lanes[2], lanes[1] | lanes[3]},
                "udsN or ldsN wrong for size and offset");
            low++;
            @(negedge CLK80);
        end
        checkThat(low == chipBusPkg::regHoldCycles, "asN low for the wrong number of cycles");
        checkThat(!tackN, "tackN missing right after the register strobe");
        @(posedge CLK80);
        regSpaceN <= 1'b1;
    endtask

    task automatic ramAccess(input logic rd, input logic [1:0] s, input logic [20:0] addr);
        int n;
        int rasAt;
        int casAt;
        logic [20:0] shifted;
        logic [chipBusPkg::cmaWidth-1:0] rowExp;
        logic [chipBusPkg::cmaWidth-1:0] colExp;
        logic [3:0] lanes;
        shifted = addr >> chipBusPkg::rowLsb;
        rowExp = shifted[chipBusPkg::cmaWidth-1:0];
        shifted = addr >> 2;
        colExp = shifted[chipBusPkg::cmaWidth-1:0];
        lanes = expectedLanes(s, addr[1:0]);
        n = 0;
        rasAt = -1;
        casAt = -1;
        @(posedge CLK80);
        tsN <= 1'b0;
        ramSpaceN <= 1'b0;
        rnW <= rd;
        siz <= s;
        a <= addr;
        tsIssued++;
        @(posedge CLK80);
        tsN <= 1'b1;
        while (tackN && n < waitLimit) begin
            @(negedge CLK80);
            n++;
            if (!rasN && rasAt < 0) begin
                rasAt = n;
                checkThat(casN && cma == rowExp, "row address not on cma with rasN");
            end
            if (!casN && casAt < 0) begin
                casAt = n;
                checkThat(cma == colExp, "column address not on cma with casN");
                checkThat(weN == ~rd && dbDir == rd && !dbEnN && !vbEnN, "weN or buffers wrong");
                checkThat({cuubeN, cumbeN, clmbeN, cllbeN} == ~{lanes[0], lanes[1], lanes[2],
                    lanes[3]}, "byte enables wrong for size and offset");
                checkThat(udsN && ldsN, "data strobes active outside a register cycle");
            end
        end
        checkThat(!tackN, "timed out waiting for tackN on a RAM cycle");
        checkThat(rasAt == 1, "rasN did not fall one cycle after tsN");
        checkThat(casAt == rasAt + chipBusPkg::rasToCas, "casN not rasToCas after rasN");
        checkThat(n == ramLatency, "tackN not at the expected RAM latency");
        @(posedge CLK80);
        ramSpaceN <= 1'b1;
    endtask

    task automatic dmaWindow(input logic aweLevel, input logic [20:0] addr);
        int n;
        int tacksBefore;
        n = 0;
        @(posedge CLK80);
        dbrN <= 1'b0;
        aweN <= aweLevel;
        while (drdEnN && n < waitLimit) begin
            @(negedge CLK80);
            n++;
        end
        checkThat(!drdEnN, "drdEnN never went low for the DMA window");
        tacksBefore = tackSeen;
        @(posedge CLK80);
        tsN <= 1'b0;
        ramSpaceN <= 1'b0;
        rnW <= 1'b1;
        siz <= chipBusPkg::sizeLong;
        a <= addr;
        tsIssued++;
        @(posedge CLK80);
        tsN <= 1'b1;
        // Request parked behind Agnus
        repeat (20) begin
            @(negedge CLK80);
            checkThat(rasN && tackN, "RAM cycle ran while DMA held the bus");
            checkThat(!drdEnN && drdDir == aweLevel, "drdEnN or drdDir wrong in DMA");
        end
        @(posedge CLK80);
        dbrN <= 1'b1;
        n = 0;
        while (tackN && n < waitLimit) begin
            @(negedge CLK80);
            n++;
        end
        checkThat(!tackN, "parked request never terminated after DMA release");
        repeat (4) @(negedge CLK80);
        checkThat(tackSeen == tacksBefore + 1, "parked request did not get exactly one tackN");
        @(posedge CLK80);
        ramSpaceN <= 1'b1;
    endtask

    task automatic randomRamAccess();
        logic rd;
        logic [1:0] s;
        logic [20:0] addr;
        s = 2'(takeBits(2));
        addr = 21'(takeBits(21));
        rd = (takeBits(1) == 1);
        ramAccess(rd, s, addr);
    endtask

    task automatic randomRegAccess();
        logic [1:0] s;
        logic [20:0] addr;
        s = 2'(takeBits(2));
        addr = 21'(takeBits(21));
        regAccess(s, addr);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        RESETn = 1'b0;
        tsN = 1'b1;
        rnW = 1'b1;
        regSpaceN = 1'b1;
        ramSpaceN = 1'b1;
        dbrN = 1'b1;
        aweN = 1'b1;
        siz = chipBusPkg::sizeLong;
        a = '0;
        lfsrState = 16'd41;

        startTest();
        resetTest();
        endTest("reset");

        startTest();
        regAccess(chipBusPkg::sizeWord, 21'h1FF01C);
        regAccess(chipBusPkg::sizeByte, 21'h1FF003);
        regAccess(chipBusPkg::sizeLong, 21'h1FF180);
        endTest("register access");

        startTest();
        ramAccess(1'b1, chipBusPkg::sizeLong, 21'h1A5F3C);
        ramAccess(1'b0, chipBusPkg::sizeWord, 21'h0ABCDE);
        ramAccess(1'b0, chipBusPkg::sizeByte, 21'h000801);
        ramAccess(1'b1, chipBusPkg::sizeThree, 21'h1FFFFD);
        endTest("cpu ram cycle");

        startTest();
        dmaWindow(1'b0, 21'h04321C);
        dmaWindow(1'b1, 21'h1C0A40);
        endTest("dma hold-off");

        startTest();
        repeat (8) randomRamAccess();
        repeat (4) randomRegAccess();
        endTest("byte lanes");

        startTest();
        repeat (4) @(negedge CLK80);
        checkThat(tackSeen == tsIssued, "count of tackN pulses differs from tsN count");
        endTest("termination");

        errorCount += chipBusTop_i.chipBusSva_i.assertFails;
        $display("Tests %0d, checks %0d, assertion failures %0d, errors %0d", testNumber,
            checkCount, chipBusTop_i.chipBusSva_i.assertFails, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* chipBus.f */
source/chipBusPkg.sv
source/registerCycle.sv
source/chipRamCycle.sv
source/dataLaneControl.sv
source/cycleTerm.sv
source/chipBusTop.sv
tests/chipBus_sva.sv
tests/chipBusTb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --assert --timing -Wno-fatal -j 0
LINTFLAGS := --lint-only -Wall --assert --timing
RUNFLAGS  := +verilator+error+limit+1000
TOP       := chipBusTb
FILELIST  := chipBus.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)

.PHONY: all lint clean

all: $(SIM)
	@out="$$(./$(SIM) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
